// File: tb.f
+incdir+tb
design/riscv_pkg.sv
design/riscv_lsu.sv
design/riscv_dmem.sv
design/riscv_wb.sv
design/riscv_regfile.sv
design/riscv_memwb_top.sv
tb/riscv_memwb_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = riscv_memwb_tb
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/memwb_tests.svh
//////////////////////////////////////////////////////////////////////
// Stimulus helpers
//////////////////////////////////////////////////////////////////////

// LCG step with Numerical Recipes constants
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Load from rs1 x0 at zero offset
function automatic logic [31:0] load_instr(input logic [2:0] f3, input logic [4:0] rd);
  return {12'h000, 5'd0, f3, rd, riscv_pkg::opc_load, 2'b11};
endfunction

// Store with both registers x0
function automatic logic [31:0] store_instr(input logic [2:0] f3);
  return {7'h00, 5'd0, 5'd0, f3, 5'd0, riscv_pkg::opc_store, 2'b11};
endfunction

// addi rd,x0,0
function automatic logic [31:0] alu_instr(input logic [4:0] rd);
  return {12'h000, 5'd0, 3'b000, rd, riscv_pkg::opc_op_imm, 2'b11};
endfunction

// Live op at the next PC
function automatic riscv_pkg::mem_stage_t make_op(input logic [31:0] instr,
    input logic [31:0] adr, input logic [31:0] sdata, input logic [31:0] r);
  riscv_pkg::mem_stage_t op;
  op        = '0;
  op.pc     = pc_next;
  op.instr  = instr;
  op.memadr = adr;
  op.sdata  = sdata;
  op.r      = r;
  pc_next   = pc_next + 32'd4;
  return op;
endfunction

// Bubbled nop between ops
function automatic riscv_pkg::mem_stage_t idle_op();
  riscv_pkg::mem_stage_t op;
  op        = '0;
  op.instr  = riscv_pkg::instr_nop;
  op.bubble = 1'b1;
  return op;
endfunction

// Sign or zero extended byte or half at a byte offset
function automatic logic [31:0] load_expect(input logic [31:0] word, input logic [1:0] off,
    input logic [2:0] f3);
  logic [7:0]  b;
  logic [15:0] h;
  b = word[{off, 3'b000} +: 8];
  h = off[1] ? word[31:16] : word[15:0];
  case (f3)
    riscv_pkg::f3_b:  return {{24{b[7]}}, b};
    riscv_pkg::f3_bu: return {24'h0, b};
    riscv_pkg::f3_h:  return {{16{h[15]}}, h};
    riscv_pkg::f3_hu: return {16'h0, h};
    default:          return word;
  endcase
endfunction

// Memory word after a store of the given size
function automatic logic [31:0] merge_store(input logic [31:0] word, input logic [1:0] off,
    input logic [2:0] f3, input logic [31:0] sdata);
  logic [31:0] res;
  res = word;
  if (f3 == riscv_pkg::f3_b)
    res[{off, 3'b000} +: 8] = sdata[7:0];
  else if (f3 == riscv_pkg::f3_h && off[1])
    res[31:16] = sdata[15:0];
  else if (f3 == riscv_pkg::f3_h)
    res[15:0] = sdata[15:0];
  else
    res = sdata;
  return res;
endfunction

// Drive on a falling edge and count stall cycles up to the capture edge
task automatic issue(input riscv_pkg::mem_stage_t op, output int stalls);
  stalls = 0;
  mem    = op;
  #(clk_period/4);
  while (wb_stall)
  begin
    stalls++;
    @(negedge clk);
    #(clk_period/4);
  end
  @(negedge clk);
  // Park on a bubble until the next op
  mem = idle_op();
endtask

//////////////////////////////////////////////////////////////////////
// Checks and reporting
//////////////////////////////////////////////////////////////////////

task automatic report_mismatch(input string test, input string item, input logic [31:0] exp,
    input logic [31:0] act);
  error_count++;
  $display("Error %s %s: expected %h actual %h", test, item, exp, act);
endtask

task automatic finish_test(input string test, input int errors_before);
  tests_run++;
  if (error_count == errors_before)
    $display("%s: ok", test);
  else
  begin
    tests_failed++;
    $display("%s: %0d errors", test, error_count - errors_before);
  end
endtask

// Load with stall, exception and either data or fault address checked
task automatic load_check(input string test, input logic [2:0] f3, input logic [31:0] adr,
    input logic [31:0] exp, input logic [31:0] exp_exc);
  int stalls;
  issue(make_op(load_instr(f3, 5'd9), adr, 32'h0, 32'h0), stalls);
  if (stalls != 1)
    report_mismatch(test, "stall cycles", 32'd1, 32'(stalls));
  if (32'(wb_exception) !== exp_exc)
    report_mismatch(test, "wb_exception", exp_exc, 32'(wb_exception));
  if (exp_exc == 32'h0)
  begin
    if (wb_we !== 1'b1)
      report_mismatch(test, "wb_we", 32'd1, 32'(wb_we));
    if (wb_r !== exp)
      report_mismatch(test, "load data", exp, wb_r);
  end
  else
  begin
    if (wb_we !== 1'b0)
      report_mismatch(test, "wb_we", 32'd0, 32'(wb_we));
    if (wb_badaddr !== adr)
      report_mismatch(test, "wb_badaddr", adr, wb_badaddr);
  end
endtask

// Store never writes a register
task automatic store_check(input string test, input logic [2:0] f3, input logic [31:0] adr,
    input logic [31:0] sdata, input logic [31:0] exp_exc);
  int stalls;
  issue(make_op(store_instr(f3), adr, sdata, 32'h0), stalls);
  if (stalls != 1)
    report_mismatch(test, "stall cycles", 32'd1, 32'(stalls));
  if (wb_we !== 1'b0)
    report_mismatch(test, "wb_we", 32'd0, 32'(wb_we));
  if (32'(wb_exception) !== exp_exc)
    report_mismatch(test, "wb_exception", exp_exc, 32'(wb_exception));
  if (exp_exc != 32'h0 && wb_badaddr !== adr)
    report_mismatch(test, "wb_badaddr", adr, wb_badaddr);
endtask

// Op passed through without memory and its bad address at pc
task automatic stage_check(input string test, input riscv_pkg::mem_stage_t op);
  if (wb_pc !== op.pc)
    report_mismatch(test, "wb_pc", op.pc, wb_pc);
  if (wb_instr !== op.instr)
    report_mismatch(test, "wb_instr", op.instr, wb_instr);
  if (wb_bubble !== op.bubble)
    report_mismatch(test, "wb_bubble", 32'(op.bubble), 32'(wb_bubble));
  if (wb_badaddr !== op.pc)
    report_mismatch(test, "wb_badaddr", op.pc, wb_badaddr);
  if (wb_we !== 1'b0)
    report_mismatch(test, "wb_we", 32'd0, 32'(wb_we));
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic reset_values();
  int errs;
  errs = error_count;
  if (wb_we !== 1'b0)
    report_mismatch("reset_values", "wb_we", 32'd0, 32'(wb_we));
  if (wb_bubble !== 1'b1)
    report_mismatch("reset_values", "wb_bubble", 32'd1, 32'(wb_bubble));
  if (wb_pc !== riscv_pkg::pc_init)
    report_mismatch("reset_values", "wb_pc", riscv_pkg::pc_init, wb_pc);
  if (wb_instr !== riscv_pkg::instr_nop)
    report_mismatch("reset_values", "wb_instr", riscv_pkg::instr_nop, wb_instr);
  if (wb_exception !== '0)
    report_mismatch("reset_values", "wb_exception", 32'd0, 32'(wb_exception));
  if (wb_badaddr !== '0)
    report_mismatch("reset_values", "wb_badaddr", 32'd0, wb_badaddr);
  finish_test("reset_values", errs);
endtask

task automatic alu_writeback();
  riscv_pkg::mem_stage_t op;
  logic [31:0]           r;
  logic [4:0]            rd;
  int                    stalls;
  int                    errs;
  errs = error_count;
  r    = next_rand();
  rd   = 5'(next_rand() % 31 + 1);
  op   = make_op(alu_instr(rd), 32'h0, 32'h0, r);
  issue(op, stalls);
  if (stalls != 0)
    report_mismatch("alu_writeback", "stall cycles", 32'd0, 32'(stalls));
  if (wb_we !== 1'b1)
    report_mismatch("alu_writeback", "wb_we", 32'd1, 32'(wb_we));
  if (wb_dst !== rd)
    report_mismatch("alu_writeback", "wb_dst", 32'(rd), 32'(wb_dst));
  if (wb_r !== r)
    report_mismatch("alu_writeback", "wb_r", r, wb_r);
  if (wb_pc !== op.pc)
    report_mismatch("alu_writeback", "wb_pc", op.pc, wb_pc);
  // Register file takes it one edge later
  rs_addr = rd;
  @(negedge clk);
  if (rs_data !== r)
    report_mismatch("alu_writeback", "rs_data", r, rs_data);
  // Same op aimed at x0
  op = make_op(alu_instr(5'd0), 32'h0, 32'h0, next_rand());
  issue(op, stalls);
  if (wb_we !== 1'b0)
    report_mismatch("alu_writeback", "wb_we x0", 32'd0, 32'(wb_we));
  rs_addr = 5'd0;
  @(negedge clk);
  if (rs_data !== 32'h0)
    report_mismatch("alu_writeback", "rs_data x0", 32'h0, rs_data);
  finish_test("alu_writeback", errs);
endtask

task automatic store_load_sizes();
  logic [31:0] adr;
  logic [31:0] word;
  logic [31:0] data;
  logic [1:0]  off;
  int          i;
  int          errs;
  errs = error_count;
  adr  = {22'h0, 8'(next_rand() % 255 + 1), 2'b00};
  word = next_rand();
  store_check("store_load_sizes", riscv_pkg::f3_w, adr, word, 32'h0);
  for (i = 0; i < 4; i++)
  begin
    load_check("store_load_sizes", riscv_pkg::f3_b, adr + i,
               load_expect(word, 2'(i), riscv_pkg::f3_b), 32'h0);
    load_check("store_load_sizes", riscv_pkg::f3_bu, adr + i,
               load_expect(word, 2'(i), riscv_pkg::f3_bu), 32'h0);
  end
  for (i = 0; i < 4; i += 2)
  begin
    load_check("store_load_sizes", riscv_pkg::f3_h, adr + i,
               load_expect(word, 2'(i), riscv_pkg::f3_h), 32'h0);
    load_check("store_load_sizes", riscv_pkg::f3_hu, adr + i,
               load_expect(word, 2'(i), riscv_pkg::f3_hu), 32'h0);
  end
  load_check("store_load_sizes", riscv_pkg::f3_w, adr, word, 32'h0);
  // Byte then half into the same word
  off  = 2'(next_rand() % 4);
  data = next_rand();
  store_check("store_load_sizes", riscv_pkg::f3_b, adr + off, data, 32'h0);
  word = merge_store(word, off, riscv_pkg::f3_b, data);
  off  = {~off[1], 1'b0};
  data = next_rand();
  store_check("store_load_sizes", riscv_pkg::f3_h, adr + off, data, 32'h0);
  word = merge_store(word, off, riscv_pkg::f3_h, data);
  load_check("store_load_sizes", riscv_pkg::f3_w, adr, word, 32'h0);
  finish_test("store_load_sizes", errs);
endtask

task automatic misaligned_access();
  logic [31:0] adr;
  logic [31:0] word;
  int          errs;
  errs = error_count;
  adr  = {22'h0, 8'(next_rand() % 255 + 1), 2'b00};
  word = next_rand();
  store_check("misaligned_access", riscv_pkg::f3_w, adr, word, 32'h0);
  load_check("misaligned_access", riscv_pkg::f3_w, adr + 2, 32'h0,
             32'h1 << riscv_pkg::cause_misaligned_load);
  store_check("misaligned_access", riscv_pkg::f3_h, adr + 1, next_rand(),
              32'h1 << riscv_pkg::cause_misaligned_store);
  // Word must be as first stored
  load_check("misaligned_access", riscv_pkg::f3_w, adr, word, 32'h0);
  finish_test("misaligned_access", errs);
endtask

task automatic access_fault();
  logic [31:0] word;
  int          errs;
  errs = error_count;
  word = next_rand();
  // Word 0 shares its index with byte address 1024
  store_check("access_fault", riscv_pkg::f3_w, 32'h0, word, 32'h0);
  load_check("access_fault", riscv_pkg::f3_w, 32'h400 + {22'h0, 8'(next_rand()), 2'b00},
             32'h0, 32'h1 << riscv_pkg::cause_load_access_fault);
  store_check("access_fault", riscv_pkg::f3_w, 32'h400, next_rand(),
              32'h1 << riscv_pkg::cause_store_access_fault);
  load_check("access_fault", riscv_pkg::f3_w, 32'h0, word, 32'h0);
  finish_test("access_fault", errs);
endtask

task automatic bubble_and_exception();
  riscv_pkg::mem_stage_t op;
  int                    stalls;
  int                    errs;
  errs      = error_count;
  op        = make_op(load_instr(riscv_pkg::f3_w, 5'd10), 32'h8, 32'h0, 32'h0);
  op.bubble = 1'b1;
  issue(op, stalls);
  if (stalls != 0)
    report_mismatch("bubble_and_exception", "stall cycles", 32'd0, 32'(stalls));
  stage_check("bubble_and_exception", op);
  // Incoming causes kept clear of the memory bits
  op           = make_op(load_instr(riscv_pkg::f3_w, 5'd10), 32'h8, 32'h0, 32'h0);
  op.exception = 12'(next_rand() & 32'h0000_0f0f) | 12'h001;
  issue(op, stalls);
  if (stalls != 0)
    report_mismatch("bubble_and_exception", "stall cycles", 32'd0, 32'(stalls));
  if (wb_exception !== op.exception)
    report_mismatch("bubble_and_exception", "wb_exception", 32'(op.exception),
                    32'(wb_exception));
  stage_check("bubble_and_exception", op);
  finish_test("bubble_and_exception", errs);
endtask

// File: tb/riscv_memwb_tb.sv
`timescale 1ns/1ns

module riscv_memwb_tb;

  // Clock period and run limit
  localparam int clk_period = 100;
  localparam int max_cycles = 400;   // well above the summed test lengths

  logic                                 clk;
  logic                                 rstn;
  riscv_pkg::mem_stage_t                mem;
  logic [4:0]                           rs_addr;
  logic                                 wb_stall;
  logic [riscv_pkg::xlen-1:0]           wb_pc;
  logic [31:0]                          wb_instr;
  logic                                 wb_bubble;
  logic [riscv_pkg::exception_size-1:0] wb_exception;
  logic [riscv_pkg::xlen-1:0]           wb_badaddr;
  logic                                 wb_we;
  logic [4:0]                           wb_dst;
  logic [riscv_pkg::xlen-1:0]           wb_r;
  logic [riscv_pkg::xlen-1:0]           rs_data;

  // Run bookkeeping
  int          cycle_count  = 0;
  int          error_count  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  logic [31:0] lcg_state;
  logic [31:0] pc_next;

  riscv_memwb_top dut0 (
    .clk          (clk),
    .rstn         (rstn),
    .mem          (mem),
    .rs_addr      (rs_addr),
    .wb_stall     (wb_stall),
    .wb_pc        (wb_pc),
    .wb_instr     (wb_instr),
    .wb_bubble    (wb_bubble),
    .wb_exception (wb_exception),
    .wb_badaddr   (wb_badaddr),
    .wb_we        (wb_we),
    .wb_dst       (wb_dst),
    .wb_r         (wb_r),
    .rs_data      (rs_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever
      #(clk_period/2) clk = ~clk;
  end

  // Ends a run that stopped making progress
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= max_cycles)
    begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  `include "memwb_tests.svh"

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rstn      = 1'b0;
    mem       = idle_op();
    rs_addr   = 5'd0;
    lcg_state = 32'hfc55_5360;
    pc_next   = 32'h0000_1000;
    // Reset held for 16 cycles, released on a falling edge
    repeat (16) @(negedge clk);
    rstn = 1'b1;

    reset_values();
    alu_writeback();
    store_load_sizes();
    misaligned_access();
    access_fault();
    bubble_and_exception();

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             error_count);
    if (error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: design/riscv_memwb_top.sv
`timescale 1ns/1ns

module riscv_memwb_top (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  riscv_pkg::mem_stage_t                mem,
  input  logic [4:0]                           rs_addr,
  output logic                                 wb_stall,
  output logic [riscv_pkg::xlen-1:0]           wb_pc,
  output logic [31:0]                          wb_instr,
  output logic                                 wb_bubble,
  output logic [riscv_pkg::exception_size-1:0] wb_exception,
  output logic [riscv_pkg::xlen-1:0]           wb_badaddr,
  output logic                                 wb_we,
  output logic [4:0]                           wb_dst,
  output logic [riscv_pkg::xlen-1:0]           wb_r,
  output logic [riscv_pkg::xlen-1:0]           rs_data
);

  // LSU to data memory
  logic                       dmem_req;
  logic                       dmem_we;
  logic [riscv_pkg::xlen-1:0] dmem_adr;
  logic [riscv_pkg::xlen-1:0] dmem_d;
  logic [3:0]                 dmem_be;
  logic [2:0]                 dmem_size;

  // Data memory response
  logic                       dmem_ack;
  logic [riscv_pkg::xlen-1:0] dmem_q;
  logic                       dmem_misaligned;
  logic                       dmem_page_fault;

  riscv_lsu lsu0 (.mem(mem), .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_adr(dmem_adr),
    .dmem_d(dmem_d), .dmem_be(dmem_be), .dmem_size(dmem_size));

  riscv_dmem dmem0 (.clk(clk), .rstn(rstn), .dmem_req(dmem_req), .dmem_we(dmem_we),
    .dmem_adr(dmem_adr), .dmem_d(dmem_d), .dmem_be(dmem_be), .dmem_size(dmem_size),
    .dmem_ack(dmem_ack), .dmem_q(dmem_q), .dmem_misaligned(dmem_misaligned),
    .dmem_page_fault(dmem_page_fault));

  riscv_wb wb0 (.clk(clk), .rstn(rstn), .mem(mem), .dmem_ack(dmem_ack), .dmem_q(dmem_q),
    .dmem_misaligned(dmem_misaligned), .dmem_page_fault(dmem_page_fault),
    .wb_stall(wb_stall), .wb_pc(wb_pc), .wb_instr(wb_instr), .wb_bubble(wb_bubble),
    .wb_exception(wb_exception), .wb_badaddr(wb_badaddr), .wb_we(wb_we),
    .wb_dst(wb_dst), .wb_r(wb_r));

  riscv_regfile rf0 (.clk(clk), .rstn(rstn), .wb_we(wb_we), .wb_dst(wb_dst), .wb_r(wb_r),
    .rs_addr(rs_addr), .rs_data(rs_data));

endmodule

// File: design/riscv_regfile.sv
`timescale 1ns/1ns

module riscv_regfile (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       wb_we,
  input  logic [4:0]                 wb_dst,
  input  logic [riscv_pkg::xlen-1:0] wb_r,
  input  logic [4:0]                 rs_addr,
  output logic [riscv_pkg::xlen-1:0] rs_data
);

  logic [riscv_pkg::xlen-1:0] regs [32];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // x0 never takes a write
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wb_we && (wb_dst != 5'd0))
    begin
      regs[wb_dst] <= wb_r;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Combinational, x0 reads as zero
  always_comb
  begin
    if (rs_addr == 5'd0)
      rs_data = '0;
    else
      rs_data = regs[rs_addr];
  end

endmodule

// File: design/riscv_wb.sv
`timescale 1ns/1ns

module riscv_wb (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  riscv_pkg::mem_stage_t                mem,
  input  logic                                 dmem_ack,
  input  logic [riscv_pkg::xlen-1:0]           dmem_q,
  input  logic                                 dmem_misaligned,
  input  logic                                 dmem_page_fault,
  output logic                                 wb_stall,
  output logic [riscv_pkg::xlen-1:0]           wb_pc,
  output logic [31:0]                          wb_instr,
  output logic                                 wb_bubble,
  output logic [riscv_pkg::exception_size-1:0] wb_exception,
  output logic [riscv_pkg::xlen-1:0]           wb_badaddr,
  output logic                                 wb_we,
  output logic [4:0]                           wb_dst,
  output logic [riscv_pkg::xlen-1:0]           wb_r
);

  riscv_pkg::opc_t                      opcode;
  logic [2:0]                           func3;
  logic [4:0]                           dst;
  logic [riscv_pkg::exception_size-1:0] exception;
  logic                                 mem_cause;
  logic [riscv_pkg::xlen-1:0]           q_shifted;
  logic [riscv_pkg::xlen-1:0]           m_data;

  assign opcode = riscv_pkg::opc_t'(mem.instr[6:2]);
  assign func3  = mem.instr[14:12];
  assign dst    = mem.instr[11:7];

  //////////////////////////////////////////////////////////////////////
  // Stall and exceptions
  //////////////////////////////////////////////////////////////////////

  // Live memory op waits for the ack
  always_comb
  begin
    wb_stall = 1'b0;
    if (!mem.bubble && !(|mem.exception) &&
        (opcode == riscv_pkg::opc_load || opcode == riscv_pkg::opc_store))
      wb_stall = ~dmem_ack;
  end

  // Memory causes merged into incoming vector
  always_comb
  begin
    exception = mem.exception;
    if (opcode == riscv_pkg::opc_load)
    begin
      if (dmem_ack)
        exception[riscv_pkg::cause_misaligned_load] = dmem_misaligned;
      exception[riscv_pkg::cause_load_access_fault] = dmem_page_fault;
    end
    if (opcode == riscv_pkg::opc_store)
    begin
      if (dmem_ack)
        exception[riscv_pkg::cause_misaligned_store] = dmem_misaligned;
      exception[riscv_pkg::cause_store_access_fault] = dmem_page_fault;
    end
  end

  assign mem_cause = exception[riscv_pkg::cause_misaligned_load]   |
                     exception[riscv_pkg::cause_load_access_fault]  |
                     exception[riscv_pkg::cause_misaligned_store]   |
                     exception[riscv_pkg::cause_store_access_fault];

  // Stage registers hold during a stall
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wb_pc        <= riscv_pkg::pc_init;
      wb_instr     <= riscv_pkg::instr_nop;
      wb_exception <= '0;
      wb_badaddr   <= '0;
    end
    else if (!wb_stall)
    begin
      wb_pc        <= mem.pc;
      wb_instr     <= mem.instr;
      wb_exception <= exception;
      wb_badaddr   <= mem_cause ? mem.memadr : mem.pc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Load data and register write
  //////////////////////////////////////////////////////////////////////

  // Addressed byte or half down to bit 0
  assign q_shifted = dmem_q >> {mem.memadr[1:0], 3'b000};

  always_comb
  begin
    case (func3)
      riscv_pkg::f3_b:  m_data = {{24{q_shifted[7]}}, q_shifted[7:0]};
      riscv_pkg::f3_h:  m_data = {{16{q_shifted[15]}}, q_shifted[15:0]};
      riscv_pkg::f3_bu: m_data = {24'h0, q_shifted[7:0]};
      riscv_pkg::f3_hu: m_data = {16'h0, q_shifted[15:0]};
      riscv_pkg::f3_w:  m_data = dmem_q;
      default:          m_data = dmem_q;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!wb_stall)
    begin
      wb_dst <= dst;
      wb_r   <= (opcode == riscv_pkg::opc_load) ? m_data : mem.r;
    end
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      wb_we <= 1'b0;
    else if (wb_stall || (|exception))
      wb_we <= 1'b0;
    else
      case (opcode)
        riscv_pkg::opc_misc_mem,
        riscv_pkg::opc_store,
        riscv_pkg::opc_branch:   wb_we <= 1'b0;
        riscv_pkg::opc_load:     wb_we <= ~mem.bubble & (|dst) & dmem_ack;
        riscv_pkg::opc_op_imm,
        riscv_pkg::opc_op,
        riscv_pkg::opc_lui,
        riscv_pkg::opc_system:   wb_we <= ~mem.bubble & (|dst);
        default:                 wb_we <= ~mem.bubble & (|dst);
      endcase
  end

  // Bubble flag one cycle behind the input
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      wb_bubble <= 1'b1;
    else if (!wb_stall)
      wb_bubble <= mem.bubble;
  end

  no_we_with_exception: assert property (@(posedge clk) disable iff (!rstn)
    wb_we |-> (wb_exception == '0));

endmodule

// File: design/riscv_dmem.sv
`timescale 1ns/1ns

module riscv_dmem (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       dmem_req,
  input  logic                       dmem_we,
  input  logic [riscv_pkg::xlen-1:0] dmem_adr,
  input  logic [riscv_pkg::xlen-1:0] dmem_d,
  input  logic [3:0]                 dmem_be,
  input  logic [2:0]                 dmem_size,
  output logic                       dmem_ack,
  output logic [riscv_pkg::xlen-1:0] dmem_q,
  output logic                       dmem_misaligned,
  output logic                       dmem_page_fault
);

  logic [riscv_pkg::xlen-1:0] mem_array [riscv_pkg::dmem_words];
  logic [$clog2(riscv_pkg::dmem_words)-1:0] word_idx;
  logic misaligned_c;
  logic wr_en;

  assign word_idx = dmem_adr[$clog2(riscv_pkg::dmem_words)+1:2];

  // Alignment per access size
  always_comb
  begin
    case (dmem_size)
      riscv_pkg::f3_h, riscv_pkg::f3_hu: misaligned_c = dmem_adr[0];
      riscv_pkg::f3_w:                   misaligned_c = |dmem_adr[1:0];
      default:                           misaligned_c = 1'b0;
    endcase
  end

  // Out of range past the last byte
  assign dmem_page_fault = dmem_req & (dmem_adr >= 4 * riscv_pkg::dmem_words);

  // One-cycle acknowledge that never repeats back to back
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      dmem_ack        <= 1'b0;
      dmem_misaligned <= 1'b0;
    end
    else
    begin
      dmem_ack        <= dmem_req & ~dmem_ack;
      dmem_misaligned <= misaligned_c;
    end
  end

  // Whole word read on the request cycle
  always_ff @(posedge clk)
  begin
    if (dmem_req && !dmem_ack)
      dmem_q <= mem_array[word_idx];
  end

  // Clean store commits on the ack edge
  assign wr_en = dmem_ack & dmem_req & dmem_we & ~dmem_misaligned & ~dmem_page_fault;

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
      if (wr_en && dmem_be[i])
        mem_array[word_idx][8*i +: 8] <= dmem_d[8*i +: 8];
  end

  // Request still up and unchanged when its ack arrives
  ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
    dmem_ack |-> (dmem_req && $past(dmem_req) && $stable(dmem_adr) && $stable(dmem_we)));

  // Faulting store leaves the addressed word as it was
  no_write_on_fault: assert property (@(posedge clk) disable iff (!rstn)
    (dmem_ack && dmem_we && dmem_page_fault) |=>
      (mem_array[$past(word_idx)] === $past(mem_array[word_idx])));

endmodule

// File: design/riscv_lsu.sv
`timescale 1ns/1ns

module riscv_lsu (
  input  riscv_pkg::mem_stage_t         mem,
  output logic                          dmem_req,
  output logic                          dmem_we,
  output logic [riscv_pkg::xlen-1:0]    dmem_adr,
  output logic [riscv_pkg::xlen-1:0]    dmem_d,
  output logic [3:0]                    dmem_be,
  output logic [2:0]                    dmem_size
);

  riscv_pkg::opc_t            opcode;
  logic [2:0]                 func3;
  logic                       is_load;
  logic                       is_store;
  logic [4:0]                 lane_shift;
  logic [riscv_pkg::xlen-1:0] sdata_masked;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign opcode = riscv_pkg::opc_t'(mem.instr[6:2]);
  assign func3  = mem.instr[14:12];

  assign is_load  = (opcode == riscv_pkg::opc_load);
  assign is_store = (opcode == riscv_pkg::opc_store);

  // Request only for live memory ops without a pending exception
  assign dmem_req = (is_load | is_store) & ~mem.bubble & ~(|mem.exception);

  // Write flag only meaningful together with the request
  assign dmem_we  = is_store & dmem_req;

  assign dmem_adr  = mem.memadr;
  assign dmem_size = func3;

  //////////////////////////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////////////////////////

  // Byte offset times eight
  assign lane_shift = {mem.memadr[1:0], 3'b000};

  // Byte enables, lane pattern moved up by the offset
  always_comb
  begin
    case (func3[1:0])
      2'b00:   dmem_be = 4'b0001 << mem.memadr[1:0];
      2'b01:   dmem_be = 4'b0011 << mem.memadr[1:0];
      default: dmem_be = 4'b1111;
    endcase
  end

  // Keep only the bytes that belong to the access size
  always_comb
  begin
    case (func3)
      riscv_pkg::f3_b: sdata_masked = {24'h0, mem.sdata[7:0]};
      riscv_pkg::f3_h: sdata_masked = {16'h0, mem.sdata[15:0]};
      riscv_pkg::f3_w: sdata_masked = mem.sdata;
      default:         sdata_masked = mem.sdata;
    endcase
  end

  // Store data placed on its lanes
  assign dmem_d = sdata_masked << lane_shift;

endmodule

// File: design/riscv_pkg.sv
package riscv_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and reset values
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int xlen           = 32;

  // One bit per exception cause
  localparam int exception_size = 12;

  // Write-back restart values
  localparam logic [xlen-1:0] pc_init   = 32'h0000_0200;
  localparam logic [31:0]     instr_nop = 32'h0000_0013;   // addi x0,x0,0

  // Data memory depth in words, 1 KiB of byte space
  localparam int dmem_words     = 256;

  //////////////////////////////////////////////////////////////////////
  // Instruction encoding
  //////////////////////////////////////////////////////////////////////

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    opc_load     = 5'b00000,
    opc_misc_mem = 5'b00011,
    opc_op_imm   = 5'b00100,
    opc_store    = 5'b01000,
    opc_op       = 5'b01100,
    opc_lui      = 5'b01101,
    opc_branch   = 5'b11000,
    opc_system   = 5'b11100
  } opc_t;

  // Access size and signedness for loads and stores
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  //////////////////////////////////////////////////////////////////////
  // Exception causes and stage payload
  //////////////////////////////////////////////////////////////////////

  // Bit positions in the exception vector
  localparam int cause_misaligned_load    = 4;
  localparam int cause_load_access_fault  = 5;
  localparam int cause_misaligned_store   = 6;
  localparam int cause_store_access_fault = 7;

  // Everything the memory stage hands over in one cycle
  typedef struct packed {
    logic [xlen-1:0]           pc;
    logic [31:0]               instr;
    logic                      bubble;
    logic [exception_size-1:0] exception;
    logic [xlen-1:0]           r;        // ALU result
    logic [xlen-1:0]           memadr;   // Effective address
    logic [xlen-1:0]           sdata;    // Store data, unshifted
  } mem_stage_t;

endpackage
